/* id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import rv_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   stall_i,
    input  id_ex_t d_i,
    output id_ex_t q_o
);

    // all-zero word is a NOP with no register write
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (stall_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

    // a stall must never let the held instruction write back
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> !q_o.wreg)
        else $error("ID/EX wrote a register after a stall");

endmodule

/* id_stage.sv */
`timescale 1ns/1ps

module id_stage import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  word_t     pc_i,
    input  inst_t     inst_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  ex_fwd_t   ex_fwd_i,
    input  fwd_src_t  mem_fwd_i,
    output logic      rs1_read_o,
    output logic      rs2_read_o,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      id_stall_o,
    output id_ex_t    id_ex_o
);

    dec_ctrl_t ctrl;
    word_t     imm;
    word_t     reg1;
    word_t     reg2;
    logic      rs1_hazard;
    logic      rs2_hazard;
    id_ex_t    id_ex_d;

    inst_decoder inst_decoder_inst (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    imm_gen imm_gen_inst (
        .inst_i (inst_i),
        .fmt_i  (ctrl.imm_fmt),
        .imm_o  (imm)
    );

    operand_fwd rs1_fwd (
        .read_i    (ctrl.rs1_read),
        .addr_i    (ctrl.rs1),
        .rf_data_i (rs1_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg1),
        .hazard_o  (rs1_hazard)
    );

    operand_fwd rs2_fwd (
        .read_i    (ctrl.rs2_read),
        .addr_i    (ctrl.rs2),
        .rf_data_i (rs2_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg2),
        .hazard_o  (rs2_hazard)
    );

    assign rs1_read_o = ctrl.rs1_read;
    assign rs2_read_o = ctrl.rs2_read;
    assign rs1_addr_o = ctrl.rs1;
    assign rs2_addr_o = ctrl.rs2;
    assign id_stall_o = rs1_hazard | rs2_hazard;

    always_comb begin
        id_ex_d.pc     = pc_i;
        id_ex_d.aluop  = ctrl.aluop;
        id_ex_d.alusel = ctrl.alusel;
        id_ex_d.reg1   = reg1;
        id_ex_d.reg2   = reg2;
        id_ex_d.wd     = ctrl.rd;
        id_ex_d.wreg   = ctrl.wreg;
        // third operand for stores, branches and jumps
        id_ex_d.offset = imm;
    end

    id_ex_reg id_ex_reg_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (id_stall_o),
        .d_i     (id_ex_d),
        .q_o     (id_ex_o)
    );

endmodule

/* imm_gen.sv */
`timescale 1ns/1ps

module imm_gen import rv_pkg::*; (
    input  inst_t    inst_i,
    input  imm_fmt_e fmt_i,
    output word_t    imm_o
);

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (fmt_i)
            IMM_I: begin
                imm_o = {{20{sign}}, inst_i[31:20]};
            end
            // shamt only, upper bits hold funct7
            IMM_SHAMT: begin
                imm_o = {27'b0, inst_i[24:20]};
            end
            IMM_S: begin
                imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            IMM_B: begin
                imm_o = {{20{sign}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{12{sign}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

/* inst_decoder.sv */
`timescale 1ns/1ps
`include "rv_settings.svh"

module inst_decoder import rv_pkg::*; (
    input  inst_t     inst_i,
    output dec_ctrl_t ctrl_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_base;
    logic       f7_alt;

    alu_op_e    aluop;
    alu_sel_e   alusel;
    imm_fmt_e   fmt;
    logic       wreg;
    logic       rd1;
    logic       rd2;
    logic       legal;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign f7_base = (funct7 == `RV_F7_BASE);
    assign f7_alt  = (funct7 == `RV_F7_ALT);

    // common to OP and OP-IMM, alt selects SUB / SRA
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? EX_SUB : EX_ADD;
            3'b001:  arith_op = EX_SLL;
            3'b010:  arith_op = EX_SLT;
            3'b011:  arith_op = EX_SLTU;
            3'b100:  arith_op = EX_XOR;
            3'b101:  arith_op = alt ? EX_SRA : EX_SRL;
            3'b110:  arith_op = EX_OR;
            default: arith_op = EX_AND;
        endcase
    endfunction

    function automatic alu_sel_e arith_sel(input logic [2:0] f3);
        case (f3)
            3'b000, 3'b010, 3'b011: arith_sel = RES_ARITH;
            3'b001, 3'b101:         arith_sel = RES_SHIFT;
            default:                arith_sel = RES_LOGIC;
        endcase
    endfunction

    always_comb begin
        aluop  = EX_NOP;
        alusel = RES_NOP;
        fmt    = IMM_NONE;
        wreg   = 1'b0;
        rd1    = 1'b0;
        rd2    = 1'b0;
        legal  = 1'b1;
        case (opcode)
            `RV_OPC_OP_IMM: begin
                // bit 30 of an addi immediate must not turn it into a sub
                aluop  = arith_op(funct3, f7_alt && (funct3 == 3'b101));
                alusel = arith_sel(funct3);
                wreg   = 1'b1;
                rd1    = 1'b1;
                fmt    = IMM_I;
                if (funct3 == 3'b001) begin
                    fmt   = IMM_SHAMT;
                    legal = f7_base;
                end else if (funct3 == 3'b101) begin
                    fmt   = IMM_SHAMT;
                    legal = f7_base || f7_alt;
                end
            end
            `RV_OPC_OP: begin
                aluop  = arith_op(funct3, f7_alt);
                alusel = arith_sel(funct3);
                wreg   = 1'b1;
                rd1    = 1'b1;
                rd2    = 1'b1;
                legal  = f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            `RV_OPC_LOAD: begin
                alusel = RES_LD_ST;
                wreg   = 1'b1;
                rd1    = 1'b1;
                fmt    = IMM_I;
                case (funct3)
                    3'b000:  aluop = EX_LB;
                    3'b001:  aluop = EX_LH;
                    3'b010:  aluop = EX_LW;
                    3'b100:  aluop = EX_LBU;
                    3'b101:  aluop = EX_LHU;
                    default: legal = 1'b0;
                endcase
            end
            `RV_OPC_STORE: begin
                alusel = RES_LD_ST;
                rd1    = 1'b1;
                rd2    = 1'b1;
                fmt    = IMM_S;
                case (funct3)
                    3'b000:  aluop = EX_SB;
                    3'b001:  aluop = EX_SH;
                    3'b010:  aluop = EX_SW;
                    default: legal = 1'b0;
                endcase
            end
            `RV_OPC_BRANCH: begin
                // branches resolve in EX without a result group
                rd1 = 1'b1;
                rd2 = 1'b1;
                fmt = IMM_B;
                case (funct3)
                    3'b000:  aluop = EX_BEQ;
                    3'b001:  aluop = EX_BNE;
                    3'b100:  aluop = EX_BLT;
                    3'b101:  aluop = EX_BGE;
                    3'b110:  aluop = EX_BLTU;
                    3'b111:  aluop = EX_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            `RV_OPC_JAL: begin
                aluop  = EX_JAL;
                alusel = RES_JAL;
                wreg   = 1'b1;
                fmt    = IMM_J;
            end
            `RV_OPC_JALR: begin
                aluop  = EX_JALR;
                alusel = RES_JAL;
                wreg   = 1'b1;
                rd1    = 1'b1;
                fmt    = IMM_I;
                legal  = (funct3 == 3'b000);
            end
            `RV_OPC_LUI: begin
                // imm reaches EX as an operand and is OR-ed through
                aluop  = EX_OR;
                alusel = RES_LOGIC;
                wreg   = 1'b1;
                fmt    = IMM_U;
            end
            `RV_OPC_AUIPC: begin
                aluop  = EX_AUIPC;
                alusel = RES_ARITH;
                wreg   = 1'b1;
                fmt    = IMM_U;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        if (!legal) begin
            aluop  = EX_NOP;
            alusel = RES_NOP;
            fmt    = IMM_NONE;
            wreg   = 1'b0;
            rd1    = 1'b0;
            rd2    = 1'b0;
        end
        // stores and branches have no destination register
        assert (!((opcode == `RV_OPC_STORE || opcode == `RV_OPC_BRANCH) && wreg))
            else $error("store or branch decoded with wreg set");
    end

    always_comb begin
        ctrl_o.aluop    = aluop;
        ctrl_o.alusel   = alusel;
        ctrl_o.wreg     = wreg;
        ctrl_o.rd       = inst_i[11:7];
        ctrl_o.rs1_read = rd1;
        ctrl_o.rs2_read = rd2;
        ctrl_o.rs1      = inst_i[19:15];
        ctrl_o.rs2      = inst_i[24:20];
        ctrl_o.imm_fmt  = fmt;
    end

endmodule

/* list.f */
+incdir+.
rv_pkg.sv
imm_gen.sv
inst_decoder.sv
operand_fwd.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

/* operand_fwd.sv */
`timescale 1ns/1ps

module operand_fwd import rv_pkg::*; (
    input  logic      read_i,
    input  reg_addr_t addr_i,
    input  word_t     rf_data_i,
    input  word_t     imm_i,
    input  ex_fwd_t   ex_fwd_i,
    input  fwd_src_t  mem_fwd_i,
    output word_t     operand_o,
    output logic      hazard_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = (ex_fwd_i.src.wd == addr_i);
    assign mem_hit = (mem_fwd_i.wd == addr_i);

    always_comb begin
        hazard_o = 1'b0;
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_fwd_i.ld_flag && ex_hit) begin
            // load data not there until MEM, stall one cycle
            operand_o = '0;
            hazard_o  = 1'b1;
        end else if (ex_fwd_i.src.wreg && ex_hit) begin
            operand_o = ex_fwd_i.src.wdata;
        end else if (mem_fwd_i.wreg && mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
        // a stalled operand never carries forwarded or register data
        assert (!hazard_o || (read_i && operand_o == '0))
            else $error("hazard raised on an unread or non-zero operand");
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the ID stage testbench, exit status reports pass or fail
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_id_stage \
        -f list.f -o sim_id_stage \
    && ./obj_dir/sim_id_stage \
    || exit 1

/* rv_pkg.sv */
package rv_pkg;

`include "rv_settings.svh"

    typedef logic [`RV_XLEN-1:0]       word_t;
    typedef logic [`RV_XLEN-1:0]       inst_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // operation handed to EX, zero is the bubble
    typedef enum logic [`RV_ALUOP_W-1:0] {
        EX_NOP = 0,
        EX_ADD, EX_SUB, EX_SLT, EX_SLTU,
        EX_XOR, EX_OR, EX_AND,
        EX_SLL, EX_SRL, EX_SRA,
        EX_LB, EX_LH, EX_LW, EX_LBU, EX_LHU,
        EX_SB, EX_SH, EX_SW,
        EX_BEQ, EX_BNE, EX_BLT, EX_BGE, EX_BLTU, EX_BGEU,
        EX_JAL, EX_JALR, EX_AUIPC
    } alu_op_e;

    // result group picked in EX
    typedef enum logic [`RV_ALUSEL_W-1:0] {
        RES_NOP = 0,
        RES_ARITH,
        RES_LOGIC,
        RES_SHIFT,
        RES_LD_ST,
        RES_JAL
    } alu_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE = 0,
        IMM_I,
        IMM_SHAMT,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        logic      wreg;
        reg_addr_t rd;
        logic      rs1_read;
        logic      rs2_read;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_fmt_e  imm_fmt;
    } dec_ctrl_t;

    // register write of a later stage, seen by the forwarding muxes
    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_src_t;

    typedef struct packed {
        logic     ld_flag;
        fwd_src_t src;
    } ex_fwd_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   aluop;
        alu_sel_e  alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        word_t     offset;
    } id_ex_t;

endpackage

/* rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath widths
`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_ALUOP_W      8
`define RV_ALUSEL_W     3

// major opcodes, inst[6:0]
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_OP       7'b0110011
`define RV_OPC_LOAD     7'b0000011
`define RV_OPC_STORE    7'b0100011
`define RV_OPC_BRANCH   7'b1100011
`define RV_OPC_JAL      7'b1101111
`define RV_OPC_JALR     7'b1100111
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_AUIPC    7'b0010111

// funct7 values for the OP / shift groups
`define RV_F7_BASE      7'b0000000
`define RV_F7_ALT       7'b0100000

`endif

/* tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

`include "rv_settings.svh"

// what one instruction should decode to
typedef struct packed {
    alu_op_e  op;
    alu_sel_e sel;
    logic     wreg;
    logic     r1;
    logic     r2;
    word_t    imm;
} exp_dec_t;

function automatic exp_dec_t mk_exp(input alu_op_e op, input alu_sel_e sel, input logic wreg,
                                    input logic r1, input logic r2, input word_t imm);
    exp_dec_t e;
    e.op   = op;
    e.sel  = sel;
    e.wreg = wreg;
    e.r1   = r1;
    e.r2   = r2;
    e.imm  = imm;
    return e;
endfunction

// sign extension of the low bits of v
function automatic word_t sext(input word_t v, input int bits);
    return word_t'($signed(v << (32 - bits)) >>> (32 - bits));
endfunction

function automatic inst_t enc_i(input logic [6:0] opc, input reg_addr_t rd, input logic [2:0] f3,
                                input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic inst_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic inst_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OPC_STORE};
endfunction

function automatic inst_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
endfunction

function automatic inst_t enc_u(input logic [6:0] opc, input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, opc};
endfunction

function automatic inst_t enc_j(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
endfunction

// RV32I funct3 tables
function automatic alu_op_e arith_rule(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? EX_SUB : EX_ADD;
        3'd1:    return EX_SLL;
        3'd2:    return EX_SLT;
        3'd3:    return EX_SLTU;
        3'd4:    return EX_XOR;
        3'd5:    return alt ? EX_SRA : EX_SRL;
        3'd6:    return EX_OR;
        default: return EX_AND;
    endcase
endfunction

function automatic alu_sel_e sel_rule(input logic [2:0] f3);
    if (f3 == 3'd1 || f3 == 3'd5) begin
        return RES_SHIFT;
    end
    return (f3 == 3'd4 || f3 >= 3'd6) ? RES_LOGIC : RES_ARITH;
endfunction

function automatic alu_op_e load_rule(input logic [2:0] f3);
    case (f3)
        3'd0:    return EX_LB;
        3'd1:    return EX_LH;
        3'd2:    return EX_LW;
        3'd4:    return EX_LBU;
        default: return EX_LHU;
    endcase
endfunction

function automatic alu_op_e store_rule(input logic [2:0] f3);
    return (f3 == 3'd0) ? EX_SB : (f3 == 3'd1) ? EX_SH : EX_SW;
endfunction

function automatic alu_op_e branch_rule(input logic [2:0] f3);
    case (f3)
        3'd0:    return EX_BEQ;
        3'd1:    return EX_BNE;
        3'd4:    return EX_BLT;
        3'd5:    return EX_BGE;
        3'd6:    return EX_BLTU;
        default: return EX_BGEU;
    endcase
endfunction

// EX beats MEM beats register file, unread operand takes the immediate
function automatic word_t operand_rule(input logic rd, input reg_addr_t a, input word_t rf,
                                       input word_t imm, input ex_fwd_t ex, input fwd_src_t mem);
    if (!rd) begin
        return imm;
    end
    if (ex.ld_flag && ex.src.wd == a) begin
        return '0;
    end
    if (ex.src.wreg && ex.src.wd == a) begin
        return ex.src.wdata;
    end
    if (mem.wreg && mem.wd == a) begin
        return mem.wdata;
    end
    return rf;
endfunction

function automatic logic hazard_rule(input logic rd, input reg_addr_t a, input ex_fwd_t ex);
    return rd && ex.ld_flag && (ex.src.wd == a);
endfunction

`endif

/* tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage import rv_pkg::*; ();

`include "tb_ref_model.svh"

    localparam int N_ITER      = 30;
    // 16 instructions per round at two cycles each plus reset
    localparam int TEST_CYCLES = 2 * 16 * N_ITER + 12;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic      clk;
    logic      rst_n;
    word_t     pc;
    inst_t     inst;
    word_t     rs1_data;
    word_t     rs2_data;
    ex_fwd_t   ex_fwd;
    fwd_src_t  mem_fwd;
    logic      rs1_read;
    logic      rs2_read;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      id_stall;
    id_ex_t    id_ex;

    // staged for the next issue
    word_t     rf1_v;
    word_t     rf2_v;
    ex_fwd_t   ex_v;
    fwd_src_t  mem_v;

    word_t     lcg_state;
    int        cycles = 0;

    id_stage id_stage_inst (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .pc_i       (pc),
        .inst_i     (inst),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_fwd_i   (ex_fwd),
        .mem_fwd_i  (mem_fwd),
        .rs1_read_o (rs1_read),
        .rs2_read_o (rs2_read),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .id_stall_o (id_stall),
        .id_ex_o    (id_ex)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            fail_stop($sformatf("timeout: tests still running after %0d cycles", cycles));
        end
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            fail_stop($sformatf("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, want));
        end
    endtask

    task automatic check_op(input string name, input alu_op_e got, input alu_op_e want);
        if (got !== want) begin
            fail_stop($sformatf("MISMATCH at %0t: %s = %0d (%s), expected %0d (%s)",
                                $time, name, got, got.name(), want, want.name()));
        end
    endtask

    task automatic check_sel(input string name, input alu_sel_e got, input alu_sel_e want);
        if (got !== want) begin
            fail_stop($sformatf("MISMATCH at %0t: %s = %0d (%s), expected %0d (%s)",
                                $time, name, got, got.name(), want, want.name()));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t want);
        if (got !== want) begin
            fail_stop($sformatf("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            fail_stop($sformatf("MISMATCH at %0t: %s = %b, expected %b", $time, name, got, want));
        end
    endtask

    task automatic expect_id_ex(input id_ex_t want);
        check_word("id_ex_o.pc", id_ex.pc, want.pc);
        check_op("id_ex_o.aluop", id_ex.aluop, want.aluop);
        check_sel("id_ex_o.alusel", id_ex.alusel, want.alusel);
        check_word("id_ex_o.reg1", id_ex.reg1, want.reg1);
        check_word("id_ex_o.reg2", id_ex.reg2, want.reg2);
        check_addr("id_ex_o.wd", id_ex.wd, want.wd);
        check_bit("id_ex_o.wreg", id_ex.wreg, want.wreg);
        check_word("id_ex_o.offset", id_ex.offset, want.offset);
    endtask

    // fresh register data and nothing in flight
    task automatic idle_stim();
        rf1_v = next_rand();
        rf2_v = next_rand();
        ex_v  = '0;
        mem_v = '0;
    endtask

    task automatic issue(input inst_t code, input exp_dec_t e);
        id_ex_t want;
        word_t  pc_v;
        logic   stall;
        pc_v      = next_rand();
        pc_v[1:0] = 2'b00;
        stall     = hazard_rule(e.r1, code[19:15], ex_v) || hazard_rule(e.r2, code[24:20], ex_v);
        want      = '0;
        // a load-use stall leaves a bubble
        if (!stall) begin
            want.pc     = pc_v;
            want.aluop  = e.op;
            want.alusel = e.sel;
            want.reg1   = operand_rule(e.r1, code[19:15], rf1_v, e.imm, ex_v, mem_v);
            want.reg2   = operand_rule(e.r2, code[24:20], rf2_v, e.imm, ex_v, mem_v);
            want.wd     = code[11:7];
            want.wreg   = e.wreg;
            want.offset = e.imm;
        end
        @(posedge clk);
        pc       <= pc_v;
        inst     <= code;
        rs1_data <= rf1_v;
        rs2_data <= rf2_v;
        ex_fwd   <= ex_v;
        mem_fwd  <= mem_v;
        @(negedge clk);
        check_bit("rs1_read_o", rs1_read, e.r1);
        check_bit("rs2_read_o", rs2_read, e.r2);
        check_addr("rs1_addr_o", rs1_addr, code[19:15]);
        check_addr("rs2_addr_o", rs2_addr, code[24:20]);
        check_bit("id_stall_o", id_stall, stall);
        @(negedge clk);
        expect_id_ex(want);
    endtask

    task automatic reset_test();
        word_t r;
        repeat (10) begin
            r = next_rand();
            @(posedge clk);
            inst <= enc_i(`RV_OPC_OP_IMM, r[4:0], 3'b000, r[9:5], r[31:20]);
            pc   <= r;
            @(negedge clk);
            expect_id_ex('0);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_id_ex('0);
    endtask

    task automatic imm_tests();
        word_t       r;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [20:0] imm21;
        logic        alt;
        word_t       imm;
        repeat (N_ITER) begin
            idle_stim();
            r     = next_rand();
            f3    = r[12:10];
            alt   = r[13] && (f3 == 3'd5);
            imm12 = r[31:20];
            imm   = sext(32'(imm12), 12);
            // shifts carry funct7 above the shift amount
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm12[11:5] = alt ? `RV_F7_ALT : `RV_F7_BASE;
                imm         = 32'(imm12[4:0]);
            end
            issue(enc_i(`RV_OPC_OP_IMM, r[4:0], f3, r[9:5], imm12),
                  mk_exp(arith_rule(f3, alt), sel_rule(f3), 1'b1, 1'b1, 1'b0, imm));
            r  = next_rand();
            f3 = 3'(r % 5);
            if (f3 > 3'd2) begin
                f3 = f3 + 3'd1;
            end
            issue(enc_i(`RV_OPC_LOAD, r[4:0], f3, r[9:5], r[31:20]),
                  mk_exp(load_rule(f3), RES_LD_ST, 1'b1, 1'b1, 1'b0, sext(32'(r[31:20]), 12)));
            r = next_rand();
            issue(enc_i(`RV_OPC_JALR, r[4:0], 3'b000, r[9:5], r[31:20]),
                  mk_exp(EX_JALR, RES_JAL, 1'b1, 1'b1, 1'b0, sext(32'(r[31:20]), 12)));
            r = next_rand();
            issue(enc_u(`RV_OPC_LUI, r[4:0], r[31:12]),
                  mk_exp(EX_OR, RES_LOGIC, 1'b1, 1'b0, 1'b0, r & 32'hFFFF_F000));
            r = next_rand();
            issue(enc_u(`RV_OPC_AUIPC, r[4:0], r[31:12]),
                  mk_exp(EX_AUIPC, RES_ARITH, 1'b1, 1'b0, 1'b0, r & 32'hFFFF_F000));
            r        = next_rand();
            imm21    = r[31:11];
            imm21[0] = 1'b0;
            issue(enc_j(r[4:0], imm21),
                  mk_exp(EX_JAL, RES_JAL, 1'b1, 1'b0, 1'b0, sext(32'(imm21), 21)));
        end
    endtask

    task automatic reg_tests();
        word_t       r;
        word_t       s;
        logic [2:0]  f3;
        logic        alt;
        logic [12:0] imm13;
        repeat (N_ITER) begin
            idle_stim();
            r   = next_rand();
            f3  = r[17:15];
            alt = r[18] && (f3 == 3'd0 || f3 == 3'd5);
            issue(enc_r(alt ? `RV_F7_ALT : `RV_F7_BASE, r[14:10], r[9:5], f3, r[4:0], `RV_OPC_OP),
                  mk_exp(arith_rule(f3, alt), sel_rule(f3), 1'b1, 1'b1, 1'b1, 32'd0));
            s  = next_rand();
            f3 = 3'(s % 3);
            issue(enc_s(s[31:20], r[14:10], r[9:5], f3),
                  mk_exp(store_rule(f3), RES_LD_ST, 1'b0, 1'b1, 1'b1, sext(32'(s[31:20]), 12)));
            s  = next_rand();
            f3 = 3'(s % 6);
            if (f3 > 3'd1) begin
                f3 = f3 + 3'd2;
            end
            imm13 = {s[31:20], 1'b0};
            issue(enc_b(imm13, r[14:10], r[9:5], f3),
                  mk_exp(branch_rule(f3), RES_NOP, 1'b0, 1'b1, 1'b1, sext(32'(imm13), 13)));
        end
    endtask

    task automatic fwd_tests();
        word_t    r;
        inst_t    code;
        exp_dec_t e;
        repeat (N_ITER) begin
            idle_stim();
            r    = next_rand();
            code = enc_r(`RV_F7_BASE, r[9:5], r[4:0], 3'b000, r[14:10], `RV_OPC_OP);
            e    = mk_exp(EX_ADD, RES_ARITH, 1'b1, 1'b1, 1'b1, 32'd0);
            // EX and MEM both write rs1 or rs2
            ex_v.src.wreg  = 1'b1;
            ex_v.src.wd    = r[15] ? r[4:0] : r[9:5];
            ex_v.src.wdata = next_rand();
            mem_v.wreg     = 1'b1;
            mem_v.wd       = ex_v.src.wd;
            mem_v.wdata    = next_rand();
            issue(code, e);
            ex_v.src.wreg = 1'b0;
            issue(code, e);
            mem_v.wreg = 1'b0;
            issue(code, e);
        end
    endtask

    task automatic stall_tests();
        word_t r;
        inst_t code;
        repeat (N_ITER) begin
            idle_stim();
            r              = next_rand();
            ex_v.ld_flag   = 1'b1;
            ex_v.src.wreg  = 1'b1;
            ex_v.src.wd    = r[15] ? r[4:0] : r[9:5];
            ex_v.src.wdata = next_rand();
            issue(enc_r(`RV_F7_BASE, r[9:5], r[4:0], 3'b000, r[14:10], `RV_OPC_OP),
                  mk_exp(EX_ADD, RES_ARITH, 1'b1, 1'b1, 1'b1, 32'd0));
            // the rs1 field of LUI holds immediate bits and is never read
            code        = enc_u(`RV_OPC_LUI, r[14:10], r[31:12]);
            ex_v.src.wd = code[19:15];
            issue(code, mk_exp(EX_OR, RES_LOGIC, 1'b1, 1'b0, 1'b0, r & 32'hFFFF_F000));
        end
    endtask

    task automatic illegal_tests();
        word_t r;
        repeat (N_ITER) begin
            idle_stim();
            r = next_rand();
            issue({r[31:7], 7'b1110111}, mk_exp(EX_NOP, RES_NOP, 1'b0, 1'b0, 1'b0, 32'd0));
            issue(enc_r(7'b0000001, r[24:20], r[19:15], r[14:12], r[11:7], `RV_OPC_OP),
                  mk_exp(EX_NOP, RES_NOP, 1'b0, 1'b0, 1'b0, 32'd0));
        end
    endtask

    initial begin
        lcg_state = 32'd54;
        clk       = 1'b0;
        rst_n    <= 1'b0;
        pc       <= '0;
        inst     <= '0;
        rs1_data <= '0;
        rs2_data <= '0;
        ex_fwd   <= '0;
        mem_fwd  <= '0;
        reset_test();
        imm_tests();
        reg_tests();
        fwd_tests();
        stall_tests();
        illegal_tests();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
